// File: verilog/cpu_pkg.sv
package cpu_pkg;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam string IMEM_FILE = "tb/program.hex";

	// Primary opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti = 6'h0a;
	localparam logic [5:0] op_sltiu = 6'h0b;
	localparam logic [5:0] op_andi = 6'h0c;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	// R-type function field
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jr = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_nor = 6'h27;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_and = 4'd2;
	localparam logic [3:0] alu_or = 4'd3;
	localparam logic [3:0] alu_nor = 4'd4;
	localparam logic [3:0] alu_slt = 4'd5;
	localparam logic [3:0] alu_sltu = 4'd6;
	localparam logic [3:0] alu_sll = 4'd7;
	localparam logic [3:0] alu_srl = 4'd8;
	localparam logic [3:0] alu_lui = 4'd9;
	localparam logic [3:0] alu_ne = 4'd10;
	localparam logic [3:0] alu_eq = 4'd11;

	typedef enum logic [1:0] {wbsel_alu, wbsel_load, wbsel_link} wbsel_t;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		logic rfw;
		wbsel_t wbsel;
		logic drw;
		logic [3:0] alu_op;
		logic use_imm;
		logic is_branch;
		logic is_jump;
		logic is_jr;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] waddr;
		logic [4:0] shamt;
		logic [31:0] rfa;
		logic [31:0] rfb;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [25:0] jaddr;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic rfw;
		wbsel_t wbsel;
		logic drw;
		logic [31:0] alu_r;
		logic [31:0] rfb;
		logic [4:0] waddr;
		logic [31:0] link;
	} ex_mem_t;

	typedef struct packed {
		logic rfw;
		logic [4:0] waddr;
		logic [31:0] wdata;
	} wb_t;

	typedef struct packed {
		logic taken;
		logic [31:0] target;
	} redirect_t;

endpackage

// File: verilog/cpu_if.sv
`timescale 1ns/1ps

module cpu_if import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input redirect_t redirect,
	output if_id_t if_id
);

	logic [31:0] pc;
	logic [31:0] imem [IMEM_WORDS];

	initial begin
		$readmemh(IMEM_FILE, imem);
	end

	always_ff @(posedge clk) begin
		if (!stall || redirect.taken) begin
			if_id.pc <= pc;
			if_id.instr <= imem[pc[$clog2(IMEM_WORDS)+1:2]]; // Word index
		end

		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (redirect.taken) begin
			pc <= redirect.target;
			if_id.valid <= 1'b0; // Squash the fetch after the delay slot
		end else if (!stall) begin
			pc <= pc + 32'd4;
			if_id.valid <= 1'b1;
		end
	end

endmodule

// File: verilog/cpu_id.sv
`timescale 1ns/1ps

module cpu_id import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input if_id_t if_id,
	input redirect_t redirect,
	input wb_t wb,
	output id_ex_t id_ex,
	output logic stall
);

	logic [31:0] rf [32];
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic wr;
	logic uses_rs;
	logic uses_rt;
	logic load_use;
	id_ex_t dec;

	assign op = if_id.instr[31:26];
	assign fn = if_id.instr[5:0];
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];

	// Register file, write-through from writeback
	always_ff @(posedge clk) begin
		if (wb.rfw)
			rf[wb.waddr] <= wb.wdata;
	end

	assign rs_val = (rs == 5'd0) ? '0 :
		(wb.rfw && wb.waddr == rs) ? wb.wdata : rf[rs];
	assign rt_val = (rt == 5'd0) ? '0 :
		(wb.rfw && wb.waddr == rt) ? wb.wdata : rf[rt];

	always_comb begin
		dec = '0;
		wr = 1'b0;
		dec.valid = if_id.valid;
		dec.rs = rs;
		dec.rt = rt;
		dec.shamt = if_id.instr[10:6];
		dec.rfa = rs_val;
		dec.rfb = rt_val;
		dec.imm = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
		dec.pc = if_id.pc;
		dec.jaddr = if_id.instr[25:0];
		dec.waddr = rt;
		dec.wbsel = wbsel_alu;
		dec.alu_op = alu_add;
		case (op)
			op_rtype: begin
				dec.waddr = rd;
				wr = 1'b1;
				case (fn)
					fn_addu: dec.alu_op = alu_add;
					fn_subu: dec.alu_op = alu_sub;
					fn_and: dec.alu_op = alu_and;
					fn_or: dec.alu_op = alu_or;
					fn_nor: dec.alu_op = alu_nor;
					fn_slt: dec.alu_op = alu_slt;
					fn_sltu: dec.alu_op = alu_sltu;
					fn_sll: dec.alu_op = alu_sll;
					fn_srl: dec.alu_op = alu_srl;
					fn_jr: begin
						wr = 1'b0;
						dec.is_jump = 1'b1;
						dec.is_jr = 1'b1;
					end
					default: wr = 1'b0;
				endcase
			end
			op_addiu: begin
				wr = 1'b1;
				dec.use_imm = 1'b1;
			end
			op_slti, op_sltiu: begin
				wr = 1'b1;
				dec.use_imm = 1'b1;
				dec.alu_op = (op == op_slti) ? alu_slt : alu_sltu;
			end
			op_andi, op_ori, op_lui: begin
				wr = 1'b1;
				dec.use_imm = 1'b1;
				dec.imm = {16'h0, if_id.instr[15:0]}; // Zero extended
				dec.alu_op = (op == op_andi) ? alu_and : (op == op_ori) ? alu_or : alu_lui;
			end
			op_lw: begin
				wr = 1'b1;
				dec.use_imm = 1'b1;
				dec.wbsel = wbsel_load;
			end
			op_sw: begin
				dec.drw = 1'b1;
				dec.use_imm = 1'b1;
			end
			op_beq, op_bne: begin
				dec.is_branch = 1'b1;
				dec.alu_op = (op == op_beq) ? alu_eq : alu_ne;
			end
			op_j: dec.is_jump = 1'b1;
			op_jal: begin
				wr = 1'b1;
				dec.is_jump = 1'b1;
				dec.waddr = 5'd31;
				dec.wbsel = wbsel_link;
			end
			default: ;
		endcase
		dec.rfw = wr && dec.waddr != 5'd0; // r0 is never written
	end

	assign uses_rs = !(op == op_j || op == op_jal || op == op_lui);
	assign uses_rt = op == op_rtype || op == op_sw || op == op_beq || op == op_bne;

	assign load_use = if_id.valid && id_ex.valid && id_ex.rfw && id_ex.wbsel == wbsel_load &&
		((uses_rs && id_ex.waddr == rs) || (uses_rt && id_ex.waddr == rt));
	assign stall = load_use && !redirect.taken;

	always_ff @(posedge clk) begin
		id_ex <= dec;
		if (rst || stall || !if_id.valid) begin // Bubble
			id_ex.valid <= 1'b0;
			id_ex.rfw <= 1'b0;
			id_ex.drw <= 1'b0;
			id_ex.is_branch <= 1'b0;
			id_ex.is_jump <= 1'b0;
		end
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
		wb.rfw |-> wb.waddr != 5'd0);

endmodule

// File: verilog/cpu_ex.sv
`timescale 1ns/1ps

module cpu_ex import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input id_ex_t id_ex,
	input wb_t wb,
	output ex_mem_t ex_mem,
	output redirect_t redirect
);

	logic [31:0] x;
	logic [31:0] rt_fwd;
	logic [31:0] y;
	logic [31:0] alu_r;
	logic [31:0] pc_4;
	logic [31:0] link;
	logic [31:0] br_target;
	logic [31:0] j_target;

	function automatic logic [31:0] fwd(input logic [4:0] r, input logic [31:0] rf_val,
		input ex_mem_t em, input wb_t w);
		logic [31:0] em_val;
		em_val = (em.wbsel == wbsel_link) ? em.link : em.alu_r;
		if (em.valid && em.rfw && em.waddr != 5'd0 && em.waddr == r)
			return em_val; // Memory stage is newer
		if (w.rfw && w.waddr != 5'd0 && w.waddr == r)
			return w.wdata;
		return rf_val;
	endfunction

	assign x = fwd(id_ex.rs, id_ex.rfa, ex_mem, wb);
	assign rt_fwd = fwd(id_ex.rt, id_ex.rfb, ex_mem, wb);
	assign y = id_ex.use_imm ? id_ex.imm : rt_fwd;

	always_comb begin
		case (id_ex.alu_op)
			alu_add: alu_r = x + y;
			alu_sub: alu_r = x - y;
			alu_and: alu_r = x & y;
			alu_or: alu_r = x | y;
			alu_nor: alu_r = ~(x | y);
			alu_slt: alu_r = {31'h0, $signed(x) < $signed(y)};
			alu_sltu: alu_r = {31'h0, x < y};
			alu_sll: alu_r = y << id_ex.shamt;
			alu_srl: alu_r = y >> id_ex.shamt;
			alu_lui: alu_r = {y[15:0], 16'h0};
			alu_ne: alu_r = {31'h0, x != y};
			alu_eq: alu_r = {31'h0, x == y};
			default: alu_r = '0;
		endcase
	end

	assign pc_4 = id_ex.pc + 32'd4;
	assign link = id_ex.pc + 32'd8; // Past the delay slot
	assign br_target = pc_4 + {id_ex.imm[29:0], 2'b00};
	assign j_target = id_ex.is_jr ? x : {pc_4[31:28], id_ex.jaddr, 2'b00};

	assign redirect.taken = id_ex.is_jump || (id_ex.is_branch && alu_r[0]);
	assign redirect.target = id_ex.is_jump ? j_target : br_target;

	always_ff @(posedge clk) begin
		ex_mem.wbsel <= id_ex.wbsel;
		ex_mem.alu_r <= alu_r;
		ex_mem.rfb <= rt_fwd; // Store data
		ex_mem.waddr <= id_ex.waddr;
		ex_mem.link <= link;
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.rfw <= 1'b0;
			ex_mem.drw <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.rfw <= id_ex.valid && id_ex.rfw;
			ex_mem.drw <= id_ex.valid && id_ex.drw;
		end
	end

	a_taken_valid: assert property (@(posedge clk) disable iff (rst)
		redirect.taken |-> id_ex.valid);

endmodule

// File: verilog/cpu_mem.sv
`timescale 1ns/1ps

module cpu_mem import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input ex_mem_t ex_mem,
	output wb_t wb
);

	logic [31:0] dmem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0] idx;

	assign idx = ex_mem.alu_r[$clog2(DMEM_WORDS)+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.drw)
			dmem[idx] <= ex_mem.rfb;
	end

	always_ff @(posedge clk) begin
		wb.waddr <= ex_mem.waddr;
		case (ex_mem.wbsel)
			wbsel_load: wb.wdata <= dmem[idx]; // Synchronous read
			wbsel_link: wb.wdata <= ex_mem.link;
			default: wb.wdata <= ex_mem.alu_r;
		endcase
		if (rst)
			wb.rfw <= 1'b0;
		else
			wb.rfw <= ex_mem.valid && ex_mem.rfw;
	end

	a_store_aligned: assert property (@(posedge clk) disable iff (rst)
		ex_mem.valid && ex_mem.drw |-> ex_mem.alu_r[1:0] == 2'b00);

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	output wb_t retire
);

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	wb_t wb;
	redirect_t redirect;
	logic stall;

	cpu_if cpu_if_i (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.if_id(if_id)
	);

	cpu_id cpu_id_i (
		.clk(clk),
		.rst(rst),
		.if_id(if_id),
		.redirect(redirect),
		.wb(wb),
		.id_ex(id_ex),
		.stall(stall)
	);

	cpu_ex cpu_ex_i (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.wb(wb),
		.ex_mem(ex_mem),
		.redirect(redirect)
	);

	cpu_mem cpu_mem_i (
		.clk(clk),
		.rst(rst),
		.ex_mem(ex_mem),
		.wb(wb)
	);

	assign retire = wb; // Every commit shows here

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // Released between edges
	end

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	logic clk;
	logic rst;
	wb_t retire;

	string names[$];
	wb_t expected[$];
	int cur;
	int passes;
	int fails;
	bit table_ready;

	clk_gen clk_gen_i (
		.clk(clk),
		.rst(rst)
	);

	cpu_top cpu_top_i (
		.clk(clk),
		.rst(rst),
		.retire(retire)
	);

	task automatic add_expected(input string name, input logic [4:0] r, input logic [31:0] v);
		wb_t e;
		e.rfw = 1'b1;
		e.waddr = r;
		e.wdata = v;
		names.push_back(name);
		expected.push_back(e);
	endtask

	// Retire order of tb/program.hex
	task automatic build_table();
		add_expected("addiu", 5'd1, 32'h0000_0005);
		add_expected("addiu_fwd1", 5'd2, 32'h0000_0002);
		add_expected("addu_fwd2", 5'd3, 32'h0000_0007);
		add_expected("lui", 5'd4, 32'h8000_0000);
		add_expected("ori_fwd1", 5'd4, 32'h8000_00ff);
		add_expected("subu", 5'd5, 32'h7fff_ff08); // Newer r4 wins
		add_expected("and", 5'd6, 32'h0000_0007);
		add_expected("or", 5'd7, 32'h8000_00ff);
		add_expected("nor", 5'd8, 32'h7fff_ff00);
		add_expected("sll", 5'd9, 32'h0000_0070);
		add_expected("srl", 5'd10, 32'h0800_000f);
		add_expected("slt", 5'd11, 32'h0000_0001);
		add_expected("sltu", 5'd12, 32'h0000_0000);
		add_expected("slti", 5'd13, 32'h0000_0000);
		add_expected("sltiu", 5'd14, 32'h0000_0001);
		add_expected("lw_after_sw", 5'd15, 32'h7fff_ff08);
		add_expected("load_use", 5'd16, 32'h7fff_ff09);
		add_expected("read_r0", 5'd17, 32'h0000_0005); // No entry for the r0 write
		add_expected("beq_delay_slot", 5'd18, 32'h0000_0012);
		add_expected("bne_delay_slot", 5'd20, 32'h0000_0014);
		add_expected("jal_link", 5'd31, 32'h0000_006c);
		add_expected("jal_delay_slot", 5'd21, 32'h0000_0015);
		add_expected("jal_target", 5'd23, 32'h0000_0017);
		add_expected("jr_delay_slot", 5'd24, 32'h0000_0018);
		add_expected("jr_return", 5'd22, 32'h0000_0016);
	endtask

	initial begin
		wb_t e;
		int fails_before;
		cur = 0;
		passes = 0;
		fails = 0;
		build_table();
		table_ready = 1'b1;
		while (rst !== 1'b0)
			@(negedge clk);
		for (int i = 0; i < names.size(); i++) begin
			cur = i;
			e = expected[i];
			@(negedge clk);
			while (retire.rfw !== 1'b1)
				@(negedge clk);
			assert (retire.waddr === e.waddr && retire.wdata === e.wdata) begin
				passes++;
				$display("%s: r%0d = %08h ok", names[i], retire.waddr, retire.wdata);
			end else begin
				fails++;
				$display("ERROR %s: expected r%0d = %08h, actual r%0d = %08h",
					names[i], e.waddr, e.wdata, retire.waddr, retire.wdata);
			end
		end
		cur = names.size();
		fails_before = fails;
		// Squashed fetches of the j loop stay off retire
		repeat (40) begin
			@(negedge clk);
			assert (retire.rfw !== 1'b1) else begin
				fails++;
				$display("ERROR extra_retire: expected none, actual r%0d = %08h",
					retire.waddr, retire.wdata);
			end
		end
		if (fails == fails_before) begin
			passes++;
			$display("extra_retire: none ok");
		end
		$display("%0d passed, %0d failed", passes, fails);
		if (fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial begin
		wait (table_ready);
		repeat ((names.size() + 20) * 4) @(posedge clk);
		if (cur < names.size())
			$display("Timeout while waiting for entry %0d (%s)", cur, names[cur]);
		else
			$display("Timeout after the last entry");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: compile.f
verilog/cpu_pkg.sv
verilog/cpu_if.sv
verilog/cpu_id.sv
verilog/cpu_ex.sv
verilog/cpu_mem.sv
verilog/cpu_top.sv
tb/clk_gen.sv
tb/cpu_tb.sv

// File: tb/program.hex
// One instruction word per line, word address 0 upward
// Columns: hex word, then byte address and assembly
24010005 // 00: addiu $1, $0, 5
2422fffd // 04: addiu $2, $1, -3
00221821 // 08: addu  $3, $1, $2
3c048000 // 0c: lui   $4, 0x8000
348400ff // 10: ori   $4, $4, 0x00ff
00642823 // 14: subu  $5, $3, $4
00833024 // 18: and   $6, $4, $3
00833825 // 1c: or    $7, $4, $3
00834027 // 20: nor   $8, $4, $3
00034900 // 24: sll   $9, $3, 4
00045102 // 28: srl   $10, $4, 4
0083582a // 2c: slt   $11, $4, $3
0083602b // 30: sltu  $12, $4, $3
286dffff // 34: slti  $13, $3, -1
2c6effff // 38: sltiu $14, $3, -1
ac050008 // 3c: sw    $5, 8($0)
8c0f0008 // 40: lw    $15, 8($0)
25f00001 // 44: addiu $16, $15, 1
24000063 // 48: addiu $0, $0, 99
00018821 // 4c: addu  $17, $0, $1
10310002 // 50: beq   $1, $17, 0x5c
24120012 // 54: addiu $18, $0, 0x12
24130013 // 58: addiu $19, $0, 0x13
14310002 // 5c: bne   $1, $17, 0x68
24140014 // 60: addiu $20, $0, 0x14
0c00001e // 64: jal   0x78
24150015 // 68: addiu $21, $0, 0x15
24160016 // 6c: addiu $22, $0, 0x16
0800001c // 70: j     0x70
00000000 // 74: nop
24170017 // 78: addiu $23, $0, 0x17
03e00008 // 7c: jr    $31
24180018 // 80: addiu $24, $0, 0x18
24190019 // 84: addiu $25, $0, 0x19
